// File: burst_cfg_pkg.sv
// Sizes are fixed for an 8-bank memory; QUEUE_DEPTH must stay a power of two for pointer wrap
package burst_cfg_pkg;

  // Banks and crossbar ports
  localparam int unsigned NUM_BANKS  = 8;
  localparam int unsigned BANK_IDX_W = 3;

  // Initiators
  localparam int unsigned NUM_INI = 4;
  localparam int unsigned INI_W   = 2;

  // Word address, bank index in the low bits and row above it
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = 4;
  localparam int unsigned BLEN_W = 4;

  // Response grouping
  localparam int unsigned RSP_GF     = 2;
  localparam int unsigned NUM_GROUPS = NUM_BANKS / RSP_GF;

  // Burst queue and bank storage
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_PTR_W = 2;
  localparam int unsigned BANK_ROWS   = 16;
  localparam int unsigned ROW_W       = 4;

endpackage

// File: burst_types_pkg.sv
// Field widths follow burst_cfg_pkg; gdata holds RSP_GF-1 extra words, lowest bank first
package burst_types_pkg;

  // Burst attributes of one crossbar request
  typedef struct packed {
    logic                               isburst;
    logic [burst_cfg_pkg::BLEN_W-1:0]   blen;
  } burst_t;

  // Grouped response marker and the words of the other banks in the group
  typedef struct packed {
    logic                                                      gvalid;
    logic [burst_cfg_pkg::DATA_W*(burst_cfg_pkg::RSP_GF-1)-1:0] gdata;
  } gresp_t;

  // One queued burst, idx is the port it came in on
  typedef struct packed {
    logic [burst_cfg_pkg::INI_W-1:0]      ini_addr;
    logic [burst_cfg_pkg::ADDR_W-1:0]     tgt_addr;
    logic [burst_cfg_pkg::DATA_W-1:0]     wdata;
    logic                                 wen;
    logic [burst_cfg_pkg::BE_W-1:0]       ben;
    logic [burst_cfg_pkg::BLEN_W-1:0]     blen;
    logic [burst_cfg_pkg::BANK_IDX_W-1:0] idx;
  } breq_t;

  typedef enum logic {
    Idle,
    DoBurst
  } req_gen_e;

endpackage

// File: bank_req_if.sv
// One request lane per bank; wen high means write, and writes never produce a response
`timescale 1ns/10ps

interface bank_req_if;

  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::INI_W-1:0]  ini_addr;
  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::ADDR_W-1:0] tgt_addr;
  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::DATA_W-1:0] wdata;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]                            wen;
  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::BE_W-1:0]   ben;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]                            valid;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]                            ready;

  modport sender (
    output ini_addr, tgt_addr, wdata, wen, ben, valid,
    input  ready
  );

  modport receiver (
    input  ini_addr, tgt_addr, wdata, wen, ben, valid,
    output ready
  );

endinterface

// File: bank_resp_if.sv
// One read response lane per bank, held by the sender until ready
`timescale 1ns/10ps

interface bank_resp_if;

  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::INI_W-1:0]  ini_addr;
  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::DATA_W-1:0] rdata;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]                            valid;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]                            ready;

  modport sender (
    output ini_addr, rdata, valid,
    input  ready
  );

  modport receiver (
    input  ini_addr, rdata, valid,
    output ready
  );

endinterface

// File: burst_req_queue.sv
// Accepts at most one burst per cycle; head_o falls through from the arbiter while the queue is empty
`timescale 1ns/10ps

module burst_req_queue (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  bank_req_if.receiver                                      req_i,
  input  burst_types_pkg::burst_t [burst_cfg_pkg::NUM_BANKS-1:0] req_burst_i,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0]               acc_o,
  output burst_types_pkg::breq_t                            head_o,
  output logic                                              head_valid_o,
  input  logic                                              pop_i
);

  logic [burst_cfg_pkg::BANK_IDX_W-1:0]  rr_q;
  logic [burst_cfg_pkg::BANK_IDX_W-1:0]  win_idx;
  logic [burst_cfg_pkg::BANK_IDX_W-1:0]  cand_idx;
  logic                                  win_valid;
  logic                                  push;
  logic                                  store;
  logic                                  drain;
  logic                                  empty;
  logic                                  full;
  burst_types_pkg::breq_t                push_entry;
  burst_types_pkg::breq_t                mem [burst_cfg_pkg::QUEUE_DEPTH];
  logic [burst_cfg_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [burst_cfg_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [burst_cfg_pkg::QUEUE_PTR_W:0]   count_q;

  // Round robin, scanned downward so the port closest to rr_q wins
  always_comb begin
    win_valid = 1'b0;
    win_idx   = rr_q;
    cand_idx  = rr_q;
    for (int k = burst_cfg_pkg::NUM_BANKS - 1; k >= 0; k--) begin
      cand_idx = rr_q + burst_cfg_pkg::BANK_IDX_W'(k);
      if (req_i.valid[cand_idx] && req_burst_i[cand_idx].isburst) begin
        win_valid = 1'b1;
        win_idx   = cand_idx;
      end
    end
  end

  assign empty = (count_q == 0);
  assign full  = (count_q == burst_cfg_pkg::QUEUE_DEPTH);
  assign push  = win_valid & ~full;
  // A push into an empty queue that is popped at once never gets stored
  assign store = push & ~(pop_i & empty);
  assign drain = pop_i & ~empty;

  always_comb begin
    acc_o          = '0;
    acc_o[win_idx] = push;
    push_entry.ini_addr = req_i.ini_addr[win_idx];
    push_entry.tgt_addr = req_i.tgt_addr[win_idx];
    push_entry.wdata    = req_i.wdata[win_idx];
    push_entry.wen      = req_i.wen[win_idx];
    push_entry.ben      = req_i.ben[win_idx];
    push_entry.blen     = req_burst_i[win_idx].blen;
    push_entry.idx      = win_idx;
  end

  assign head_o       = empty ? push_entry : mem[rd_ptr_q];
  assign head_valid_o = ~empty | push;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q     <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Priority moves just past the winner
      if (push) rr_q <= win_idx + 1'b1;
      if (store) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (drain) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (store && !drain) begin
        count_q <= count_q + 1'b1;
      end else if (drain && !store) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) mem[wr_ptr_q] <= push_entry;
  end

endmodule

// File: burst_req_expander.sv
// Bursts past the last bank are cut off; ini_addr stays the same on every bank of a burst
`timescale 1ns/10ps

module burst_req_expander (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  bank_req_if.receiver                                      req_in,
  input  burst_types_pkg::burst_t [burst_cfg_pkg::NUM_BANKS-1:0] req_burst_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]               acc_i,
  input  burst_types_pkg::breq_t                            head_i,
  input  logic                                              head_valid_i,
  output logic                                              pop_o,
  bank_req_if.sender                                        bank_req,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]               resp_pending_i,
  output logic [burst_cfg_pkg::NUM_GROUPS-1:0]              group_mask_o
);

  burst_types_pkg::req_gen_e             state_q, state_d;
  burst_types_pkg::breq_t                breq_q, breq_d;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]   lock_q, lock_d;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]   new_lock;
  logic                                  issue;

  // blen ones starting at the source port
  always_comb begin
    for (int i = 0; i < burst_cfg_pkg::NUM_BANKS; i++) begin
      new_lock[i] = (i >= int'(head_i.idx)) && (i < int'(head_i.idx) + int'(head_i.blen));
    end
  end

  always_comb begin
    state_d = state_q;
    breq_d  = breq_q;
    lock_d  = lock_q;
    pop_o   = 1'b0;
    issue   = 1'b0;
    case (state_q)
      burst_types_pkg::Idle: begin
        if (head_valid_i) begin
          pop_o   = 1'b1;
          breq_d  = head_i;
          lock_d  = new_lock;
          state_d = burst_types_pkg::DoBurst;
        end
      end
      burst_types_pkg::DoBurst: begin
        // Fire all covered banks together, none may still hold a response
        if (&(bank_req.ready | ~lock_q) && !(|(resp_pending_i & lock_q))) begin
          issue   = 1'b1;
          lock_d  = '0;
          state_d = burst_types_pkg::Idle;
        end
      end
      default: state_d = burst_types_pkg::Idle;
    endcase
  end

  always_comb begin
    for (int i = 0; i < burst_cfg_pkg::NUM_BANKS; i++) begin
      bank_req.ini_addr[i] = req_in.ini_addr[i];
      bank_req.tgt_addr[i] = req_in.tgt_addr[i];
      bank_req.wdata[i]    = req_in.wdata[i];
      bank_req.wen[i]      = req_in.wen[i];
      bank_req.ben[i]      = req_in.ben[i];
      // Plain traffic only, and never into a bank held by the burst
      bank_req.valid[i]    = req_in.valid[i] & ~req_burst_i[i].isburst & ~lock_q[i];
      req_in.ready[i]      = req_burst_i[i].isburst ? acc_i[i]
                                                    : bank_req.ready[i] & ~lock_q[i];
      if (issue && lock_q[i]) begin
        bank_req.ini_addr[i] = breq_q.ini_addr;
        bank_req.tgt_addr[i] = breq_q.tgt_addr + burst_cfg_pkg::ADDR_W'(i)
                               - burst_cfg_pkg::ADDR_W'(breq_q.idx);
        bank_req.wdata[i]    = breq_q.wdata;
        bank_req.wen[i]      = breq_q.wen;
        bank_req.ben[i]      = breq_q.ben;
        bank_req.valid[i]    = 1'b1;
      end
    end
    // Only read bursts that cover a whole group get grouped
    for (int g = 0; g < burst_cfg_pkg::NUM_GROUPS; g++) begin
      group_mask_o[g] = issue & ~breq_q.wen
                        & (&lock_q[g*burst_cfg_pkg::RSP_GF +: burst_cfg_pkg::RSP_GF]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= burst_types_pkg::Idle;
      lock_q  <= '0;
    end else begin
      state_q <= state_d;
      lock_q  <= lock_d;
    end
  end

  always_ff @(posedge clk_i) begin
    breq_q <= breq_d;
  end

endmodule

// File: burst_rsp_grouper.sv
// Grouped responses use the first port of each group; the other ports of that group stay silent
`timescale 1ns/10ps

module burst_rsp_grouper (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  bank_resp_if.receiver                                           bank_resp,
  input  logic [burst_cfg_pkg::NUM_GROUPS-1:0]                    group_mask_i,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::INI_W-1:0]  resp_ini_addr_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::DATA_W-1:0] resp_rdata_o,
  output burst_types_pkg::gresp_t [burst_cfg_pkg::NUM_BANKS-1:0]  resp_burst_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0]                     resp_valid_o,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]                     resp_ready_i,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0]                     resp_pending_o
);

  logic [burst_cfg_pkg::NUM_GROUPS-1:0] grp_q;
  logic [burst_cfg_pkg::NUM_GROUPS-1:0] all_valid;

  always_comb begin
    resp_ini_addr_o = bank_resp.ini_addr;
    resp_rdata_o    = bank_resp.rdata;
    resp_valid_o    = bank_resp.valid;
    resp_burst_o    = '0;
    bank_resp.ready = resp_ready_i;
    for (int g = 0; g < burst_cfg_pkg::NUM_GROUPS; g++) begin
      all_valid[g] = &bank_resp.valid[g*burst_cfg_pkg::RSP_GF +: burst_cfg_pkg::RSP_GF];
      if (grp_q[g]) begin
        resp_valid_o[g*burst_cfg_pkg::RSP_GF]        = all_valid[g];
        resp_burst_o[g*burst_cfg_pkg::RSP_GF].gvalid = 1'b1;
        for (int k = 0; k < burst_cfg_pkg::RSP_GF; k++) begin
          // Whole group leaves on the first port's ready
          bank_resp.ready[g*burst_cfg_pkg::RSP_GF+k] =
            resp_ready_i[g*burst_cfg_pkg::RSP_GF] & all_valid[g];
          if (k > 0) begin
            resp_burst_o[g*burst_cfg_pkg::RSP_GF].gdata[(k-1)*burst_cfg_pkg::DATA_W +:
              burst_cfg_pkg::DATA_W] = bank_resp.rdata[g*burst_cfg_pkg::RSP_GF+k];
            resp_ini_addr_o[g*burst_cfg_pkg::RSP_GF+k] = '0;
            resp_rdata_o[g*burst_cfg_pkg::RSP_GF+k]    = '0;
            resp_valid_o[g*burst_cfg_pkg::RSP_GF+k]    = 1'b0;
          end
        end
      end
    end
    resp_pending_o = bank_resp.valid & ~bank_resp.ready;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      grp_q <= '0;
    end else begin
      for (int g = 0; g < burst_cfg_pkg::NUM_GROUPS; g++) begin
        if (group_mask_i[g]) begin
          grp_q[g] <= 1'b1;
        end else if (resp_valid_o[g*burst_cfg_pkg::RSP_GF] &&
                     resp_ready_i[g*burst_cfg_pkg::RSP_GF]) begin
          grp_q[g] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: tcdm_burst_manager.sv
// Plain requests pass combinationally; bursts take at least two cycles through queue and generator
`timescale 1ns/10ps

module tcdm_burst_manager (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::INI_W-1:0]  req_ini_addr_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::ADDR_W-1:0] req_tgt_addr_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]                     req_wen_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::BE_W-1:0]   req_ben_i,
  input  burst_types_pkg::burst_t [burst_cfg_pkg::NUM_BANKS-1:0]  req_burst_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]                     req_valid_i,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0]                     req_ready_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::INI_W-1:0]  resp_ini_addr_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::DATA_W-1:0] resp_rdata_o,
  output burst_types_pkg::gresp_t [burst_cfg_pkg::NUM_BANKS-1:0]  resp_burst_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0]                     resp_valid_o,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]                     resp_ready_i,
  bank_req_if.sender                                              bank_req,
  bank_resp_if.receiver                                           bank_resp
);

  logic [burst_cfg_pkg::NUM_BANKS-1:0]  acc;
  burst_types_pkg::breq_t               head;
  logic                                 head_valid;
  logic                                 pop;
  logic [burst_cfg_pkg::NUM_GROUPS-1:0] group_mask;
  logic [burst_cfg_pkg::NUM_BANKS-1:0]  resp_pending;

  // Crossbar side requests, ready comes back from the expander
  bank_req_if xbar_req ();

  assign xbar_req.ini_addr = req_ini_addr_i;
  assign xbar_req.tgt_addr = req_tgt_addr_i;
  assign xbar_req.wdata    = req_wdata_i;
  assign xbar_req.wen      = req_wen_i;
  assign xbar_req.ben      = req_ben_i;
  assign xbar_req.valid    = req_valid_i;
  assign req_ready_o       = xbar_req.ready;

  burst_req_queue u_queue (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (xbar_req.receiver),
    .req_burst_i  (req_burst_i),
    .acc_o        (acc),
    .head_o       (head),
    .head_valid_o (head_valid),
    .pop_i        (pop)
  );

  burst_req_expander u_expander (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_in         (xbar_req.receiver),
    .req_burst_i    (req_burst_i),
    .acc_i          (acc),
    .head_i         (head),
    .head_valid_i   (head_valid),
    .pop_o          (pop),
    .bank_req       (bank_req),
    .resp_pending_i (resp_pending),
    .group_mask_o   (group_mask)
  );

  burst_rsp_grouper u_grouper (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .bank_resp       (bank_resp),
    .group_mask_i    (group_mask),
    .resp_ini_addr_o (resp_ini_addr_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_burst_o    (resp_burst_o),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .resp_pending_o  (resp_pending)
  );

endmodule

// File: tcdm_bank_array.sv
// Row is taken from the address bits above the bank index; higher address bits are ignored
`timescale 1ns/10ps

module tcdm_bank_array (
  input  logic           clk_i,
  input  logic           reset_i,
  bank_req_if.receiver   bank_req,
  bank_resp_if.sender    bank_resp
);

  for (genvar b = 0; b < burst_cfg_pkg::NUM_BANKS; b++) begin : gen_bank
    logic [burst_cfg_pkg::DATA_W-1:0] mem [burst_cfg_pkg::BANK_ROWS];
    logic [burst_cfg_pkg::ROW_W-1:0]  row;
    logic                             rsp_valid_q;
    logic [burst_cfg_pkg::DATA_W-1:0] rdata_q;
    logic [burst_cfg_pkg::INI_W-1:0]  ini_q;

    assign row = bank_req.tgt_addr[b][burst_cfg_pkg::BANK_IDX_W +: burst_cfg_pkg::ROW_W];

    // No new request while a read response waits
    assign bank_req.ready[b]     = ~rsp_valid_q;
    assign bank_resp.valid[b]    = rsp_valid_q;
    assign bank_resp.rdata[b]    = rdata_q;
    assign bank_resp.ini_addr[b] = ini_q;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        rsp_valid_q <= 1'b0;
      end else if (bank_req.valid[b] && !rsp_valid_q && !bank_req.wen[b]) begin
        rsp_valid_q <= 1'b1;
      end else if (bank_resp.ready[b]) begin
        rsp_valid_q <= 1'b0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (bank_req.valid[b] && !rsp_valid_q) begin
        if (bank_req.wen[b]) begin
          for (int k = 0; k < burst_cfg_pkg::BE_W; k++) begin
            if (bank_req.ben[b][k]) mem[row][8*k +: 8] <= bank_req.wdata[b][8*k +: 8];
          end
        end else begin
          rdata_q <= mem[row];
          ini_q   <= bank_req.ini_addr[b];
        end
      end
    end
  end

endmodule

// File: tcdm_burst_subsys.sv
// Crossbar-side ports only; the banks start with undefined contents
`timescale 1ns/10ps

module tcdm_burst_subsys (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::INI_W-1:0]  req_ini_addr_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::ADDR_W-1:0] req_tgt_addr_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]                     req_wen_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::BE_W-1:0]   req_ben_i,
  input  burst_types_pkg::burst_t [burst_cfg_pkg::NUM_BANKS-1:0]  req_burst_i,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]                     req_valid_i,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0]                     req_ready_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::INI_W-1:0]  resp_ini_addr_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0][burst_cfg_pkg::DATA_W-1:0] resp_rdata_o,
  output burst_types_pkg::gresp_t [burst_cfg_pkg::NUM_BANKS-1:0]  resp_burst_o,
  output logic [burst_cfg_pkg::NUM_BANKS-1:0]                     resp_valid_o,
  input  logic [burst_cfg_pkg::NUM_BANKS-1:0]                     resp_ready_i
);

  bank_req_if  bank_req ();
  bank_resp_if bank_resp ();

  tcdm_burst_manager u_manager (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_ini_addr_i  (req_ini_addr_i),
    .req_tgt_addr_i  (req_tgt_addr_i),
    .req_wdata_i     (req_wdata_i),
    .req_wen_i       (req_wen_i),
    .req_ben_i       (req_ben_i),
    .req_burst_i     (req_burst_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .resp_ini_addr_o (resp_ini_addr_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_burst_o    (resp_burst_o),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .bank_req        (bank_req.sender),
    .bank_resp       (bank_resp.receiver)
  );

  tcdm_bank_array u_banks (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .bank_req  (bank_req.receiver),
    .bank_resp (bank_resp.sender)
  );

endmodule

// File: tb_tcdm_burst_subsys.sv
// Banks are preloaded by plain writes before any read; responses are sampled on the falling edge
`timescale 1ns/10ps

module tb_tcdm_burst_subsys;

  localparam int NB           = burst_cfg_pkg::NUM_BANKS;
  localparam int ACC_TIMEOUT  = 50;
  localparam int RESP_TIMEOUT = 50;

  logic                                         clk_i;
  logic                                         reset_i;
  logic [NB-1:0][burst_cfg_pkg::INI_W-1:0]      req_ini_addr_i;
  logic [NB-1:0][burst_cfg_pkg::ADDR_W-1:0]     req_tgt_addr_i;
  logic [NB-1:0][burst_cfg_pkg::DATA_W-1:0]     req_wdata_i;
  logic [NB-1:0]                                req_wen_i;
  logic [NB-1:0][burst_cfg_pkg::BE_W-1:0]       req_ben_i;
  burst_types_pkg::burst_t [NB-1:0]             req_burst_i;
  logic [NB-1:0]                                req_valid_i;
  logic [NB-1:0]                                req_ready_o;
  logic [NB-1:0][burst_cfg_pkg::INI_W-1:0]      resp_ini_addr_o;
  logic [NB-1:0][burst_cfg_pkg::DATA_W-1:0]     resp_rdata_o;
  burst_types_pkg::gresp_t [NB-1:0]             resp_burst_o;
  logic [NB-1:0]                                resp_valid_o;
  logic [NB-1:0]                                resp_ready_i;

  // Reference copy of every bank row
  logic [burst_cfg_pkg::DATA_W-1:0] model_mem [NB][burst_cfg_pkg::BANK_ROWS];

  // Expected responses per port for the current step
  logic [NB-1:0]                    exp_on;
  logic [burst_cfg_pkg::DATA_W-1:0] exp_rdata [NB];
  logic [burst_cfg_pkg::DATA_W-1:0] exp_gdata [NB];
  logic [burst_cfg_pkg::INI_W-1:0]  exp_ini [NB];
  logic                             exp_g [NB];

  int mismatches;
  int timeouts;

  tcdm_burst_subsys UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Word address rule: bank in the low bits, row above it
  function automatic logic [burst_cfg_pkg::ADDR_W-1:0] make_addr(int row, int bank);
    return burst_cfg_pkg::ADDR_W'(row * NB + bank);
  endfunction

  function automatic int addr_bank(logic [burst_cfg_pkg::ADDR_W-1:0] a);
    return int'(a[burst_cfg_pkg::BANK_IDX_W-1:0]);
  endfunction

  function automatic int addr_row(logic [burst_cfg_pkg::ADDR_W-1:0] a);
    return int'(a[burst_cfg_pkg::BANK_IDX_W +: burst_cfg_pkg::ROW_W]);
  endfunction

  function automatic logic [NB-1:0] port_bit(int p);
    logic [NB-1:0] m;
    m    = '0;
    m[p] = 1'b1;
    return m;
  endfunction

  function automatic void model_write(int bank, int row, logic [31:0] data, logic [3:0] ben);
    for (int k = 0; k < burst_cfg_pkg::BE_W; k++) begin
      if (ben[k]) model_mem[bank][row][8*k +: 8] = data[8*k +: 8];
    end
  endfunction

  function automatic void report_mismatch(string what, int p, logic [31:0] got,
                                          logic [31:0] exp);
    mismatches++;
    $display("Mismatch at %0t: port %0d %s is %h, expected %h", $time, p, what, got, exp);
  endfunction

  task automatic set_req(int p, bit burst, int blen, bit wen,
                         logic [burst_cfg_pkg::ADDR_W-1:0] addr, logic [31:0] data,
                         logic [3:0] ben, int ini);
    req_ini_addr_i[p]       = burst_cfg_pkg::INI_W'(ini);
    req_tgt_addr_i[p]       = addr;
    req_wdata_i[p]          = data;
    req_wen_i[p]            = wen;
    req_ben_i[p]            = ben;
    req_burst_i[p].isburst  = burst;
    req_burst_i[p].blen     = burst_cfg_pkg::BLEN_W'(blen);
    req_valid_i[p]          = 1'b1;
  endtask

  task automatic drop_req(int p);
    req_valid_i[p] = 1'b0;
    req_burst_i[p] = '0;
    req_wen_i[p]   = 1'b0;
  endtask

  // Holds each request until it sees ready at a rising edge
  task automatic wait_accept(logic [NB-1:0] mask);
    logic [NB-1:0] pend;
    logic [NB-1:0] rdy;
    int            cycles;
    pend   = mask;
    cycles = 0;
    while (pend != '0 && cycles < ACC_TIMEOUT) begin
      #1;
      rdy = req_ready_o & pend;
      @(posedge clk_i);
      @(negedge clk_i);
      for (int p = 0; p < NB; p++) begin
        if (rdy[p]) drop_req(p);
      end
      pend   = pend & ~rdy;
      cycles++;
    end
    if (pend != '0) begin
      timeouts++;
      $display("Timeout at %0t: requests on ports %b were never accepted", $time, pend);
      for (int p = 0; p < NB; p++) begin
        if (pend[p]) drop_req(p);
      end
    end
  endtask

  task automatic set_expect(int p, logic [31:0] rdata, int ini, bit g, logic [31:0] gdata);
    exp_on[p]    = 1'b1;
    exp_rdata[p] = rdata;
    exp_ini[p]   = burst_cfg_pkg::INI_W'(ini);
    exp_g[p]     = g;
    exp_gdata[p] = gdata;
  endtask

  task automatic expect_plain(int p, logic [burst_cfg_pkg::ADDR_W-1:0] addr, int ini);
    set_expect(p, model_mem[addr_bank(addr)][addr_row(addr)], ini, 1'b0, '0);
  endtask

  // A pair that the burst covers completely answers once, on its even port
  task automatic expect_burst_read(int p, int blen, logic [burst_cfg_pkg::ADDR_W-1:0] addr,
                                   int ini);
    logic [burst_cfg_pkg::ADDR_W-1:0] a;
    int                               last;
    int                               pair;
    last = (p + blen > NB) ? NB : p + blen;
    for (int b = p; b < last; b++) begin
      a    = addr + burst_cfg_pkg::ADDR_W'(b - p);
      pair = b - (b % burst_cfg_pkg::RSP_GF);
      if (pair >= p && pair + burst_cfg_pkg::RSP_GF <= last) begin
        if (b == pair) begin
          set_expect(b, model_mem[addr_bank(a)][addr_row(a)], ini, 1'b1,
                     model_mem[addr_bank(a + 16'd1)][addr_row(a + 16'd1)]);
        end
      end else begin
        set_expect(b, model_mem[addr_bank(a)][addr_row(a)], ini, 1'b0, '0);
      end
    end
  endtask

  task automatic collect_responses();
    logic [NB-1:0] got;
    int            cycles;
    got    = '0;
    cycles = 0;
    while (got != exp_on && cycles < RESP_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      for (int p = 0; p < NB; p++) begin
        if (resp_valid_o[p] && (!exp_on[p] || got[p])) begin
          mismatches++;
          $display("Mismatch at %0t: response on port %0d was not expected", $time, p);
        end else if (resp_valid_o[p]) begin
          got[p] = 1'b1;
          if (resp_rdata_o[p] !== exp_rdata[p])
            report_mismatch("rdata", p, resp_rdata_o[p], exp_rdata[p]);
          if (resp_ini_addr_o[p] !== exp_ini[p])
            report_mismatch("ini_addr", p, resp_ini_addr_o[p], exp_ini[p]);
          if (resp_burst_o[p].gvalid !== exp_g[p])
            report_mismatch("gvalid", p, resp_burst_o[p].gvalid, exp_g[p]);
          if (resp_burst_o[p].gdata !== exp_gdata[p])
            report_mismatch("gdata", p, resp_burst_o[p].gdata, exp_gdata[p]);
        end
      end
    end
    if (got != exp_on) begin
      timeouts++;
      $display("Timeout at %0t: no response on ports %b", $time, exp_on & ~got);
    end
  endtask

  task automatic run_reads(logic [NB-1:0] mask);
    fork
      wait_accept(mask);
      collect_responses();
    join
  endtask

  task automatic write_row(int row, logic [3:0] ben);
    logic [31:0] data [NB];
    for (int b = 0; b < NB; b++) begin
      data[b] = $urandom();
      set_req(b, 1'b0, 0, 1'b1, make_addr(row, b), data[b], ben, b % burst_cfg_pkg::NUM_INI);
    end
    wait_accept('1);
    for (int b = 0; b < NB; b++) model_write(b, row, data[b], ben);
  endtask

  task automatic read_row(int row, int ini);
    exp_on = '0;
    for (int b = 0; b < NB; b++) begin
      expect_plain(b, make_addr(row, b), ini);
      set_req(b, 1'b0, 0, 1'b0, make_addr(row, b), '0, '0, ini);
    end
    run_reads('1);
  endtask

  task automatic read_plain(int p, int row, int ini);
    exp_on = '0;
    expect_plain(p, make_addr(row, p), ini);
    set_req(p, 1'b0, 0, 1'b0, make_addr(row, p), '0, '0, ini);
    run_reads(port_bit(p));
  endtask

  task automatic burst_write(int p, int blen, int row, logic [31:0] data, logic [3:0] ben,
                             int ini);
    logic [burst_cfg_pkg::ADDR_W-1:0] addr;
    logic [burst_cfg_pkg::ADDR_W-1:0] a;
    int                               last;
    addr = make_addr(row, p);
    last = (p + blen > NB) ? NB : p + blen;
    set_req(p, 1'b1, blen, 1'b1, addr, data, ben, ini);
    wait_accept(port_bit(p));
    for (int b = p; b < last; b++) begin
      a = addr + burst_cfg_pkg::ADDR_W'(b - p);
      model_write(addr_bank(a), addr_row(a), data, ben);
    end
  endtask

  task automatic burst_read(int p, int blen, int row, int ini);
    exp_on = '0;
    expect_burst_read(p, blen, make_addr(row, p), ini);
    set_req(p, 1'b1, blen, 1'b0, make_addr(row, p), '0, '0, ini);
    run_reads(port_bit(p));
  endtask

  task automatic test_after_reset();
    for (int i = 0; i < 5; i++) begin
      @(negedge clk_i);
      if (resp_valid_o !== '0) report_mismatch("resp_valid after reset", 0, resp_valid_o, 0);
    end
  endtask

  task automatic test_plain_traffic();
    for (int row = 0; row < 4; row++) write_row(row, 4'hF);
    // Partial writes on a few ports at once
    set_req(1, 1'b0, 0, 1'b1, make_addr(1, 1), $urandom(), 4'b0101, 1);
    set_req(3, 1'b0, 0, 1'b1, make_addr(2, 3), $urandom(), 4'b1000, 2);
    set_req(6, 1'b0, 0, 1'b1, make_addr(0, 6), $urandom(), 4'b0011, 3);
    model_write(1, 1, req_wdata_i[1], 4'b0101);
    model_write(3, 2, req_wdata_i[3], 4'b1000);
    model_write(6, 0, req_wdata_i[6], 4'b0011);
    wait_accept(8'b0100_1010);
    read_plain(1, 1, 3);
    read_plain(3, 2, 0);
    read_plain(6, 0, 1);
    read_row(0, 2);
  endtask

  task automatic test_burst_write();
    burst_write(2, 4, 1, $urandom(), 4'hF, 2);
    read_row(1, 0);
    // Runs off the last bank, so only banks 6 and 7 change
    burst_write(6, 4, 2, $urandom(), 4'b1110, 3);
    read_row(2, 1);
    read_row(3, 2);
  endtask

  task automatic test_burst_read();
    burst_read(2, 4, 3, 1);
    burst_read(1, 1, 0, 2);
    burst_read(3, 4, 2, 0);
  endtask

  task automatic test_concurrent_bursts();
    exp_on = '0;
    expect_burst_read(0, 4, make_addr(1, 0), 1);
    expect_burst_read(4, 4, make_addr(2, 4), 2);
    set_req(0, 1'b1, 4, 1'b0, make_addr(1, 0), '0, '0, 1);
    set_req(4, 1'b1, 4, 1'b0, make_addr(2, 4), '0, '0, 2);
    run_reads(8'b0001_0001);
  endtask

  task automatic test_backpressure();
    logic [31:0]             held_rdata;
    burst_types_pkg::gresp_t held_burst;
    int                      cycles;
    resp_ready_i = '0;
    set_req(6, 1'b1, 2, 1'b0, make_addr(2, 6), '0, '0, 3);
    wait_accept(port_bit(6));
    cycles = 0;
    while (!resp_valid_o[6] && cycles < RESP_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!resp_valid_o[6]) begin
      timeouts++;
      $display("Timeout at %0t: held burst response never appeared on port 6", $time);
    end else begin
      held_rdata = resp_rdata_o[6];
      held_burst = resp_burst_o[6];
      if (held_rdata !== model_mem[6][2]) report_mismatch("rdata", 6, held_rdata, model_mem[6][2]);
      if (held_burst.gdata !== model_mem[7][2])
        report_mismatch("gdata", 6, held_burst.gdata, model_mem[7][2]);
      for (int i = 0; i < 20; i++) begin
        @(negedge clk_i);
        if (resp_valid_o[6] !== 1'b1) report_mismatch("held valid", 6, resp_valid_o[6], 1);
        if (resp_rdata_o[6] !== held_rdata) report_mismatch("held rdata", 6, resp_rdata_o[6], held_rdata);
        if (resp_burst_o[6] !== held_burst)
          report_mismatch("held gdata", 6, resp_burst_o[6].gdata, held_burst.gdata);
        if (req_ready_o[6] !== 1'b0) report_mismatch("req_ready while held", 6, req_ready_o[6], 0);
      end
    end
    resp_ready_i = '1;
    @(negedge clk_i);
    if (resp_valid_o[6] !== 1'b0) report_mismatch("valid after release", 6, resp_valid_o[6], 0);
  endtask

  initial begin
    void'($urandom(28));
    mismatches     = 0;
    timeouts       = 0;
    exp_on         = '0;
    reset_i        = 1'b1;
    req_ini_addr_i = '0;
    req_tgt_addr_i = '0;
    req_wdata_i    = '0;
    req_wen_i      = '0;
    req_ben_i      = '0;
    req_burst_i    = '0;
    req_valid_i    = '0;
    resp_ready_i   = '1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_after_reset();
    test_plain_traffic();
    test_burst_write();
    test_burst_read();
    test_concurrent_bursts();
    test_backpressure();
    $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
burst_cfg_pkg.sv
burst_types_pkg.sv
bank_req_if.sv
bank_resp_if.sv
burst_req_queue.sv
burst_req_expander.sv
burst_rsp_grouper.sv
tcdm_burst_manager.sv
tcdm_bank_array.sv
tcdm_burst_subsys.sv
tb_tcdm_burst_subsys.sv
